/* source/v33_defs.svh */
`ifndef V33_DEFS_SVH
`define V33_DEFS_SVH

`define V33_WORD_W   16 // Data and address width
`define V33_NUM_REGS 8
`define V33_COND_W   4  // Branch condition code

`endif

/* source/v33_isa_pkg.sv */
package v33_isa_pkg;

// Instruction class from the pre-decoder
typedef enum logic [2:0] {
    NOP,
    MOV,
    ALU,
    B_COND,
    B_CW_COND,
    BR_REL
} opcode_e;

typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    PASS
} alu_op_e;

// Where an operand comes from or a result goes to
typedef enum logic [2:0] {
    NONE,
    ACC,
    IMM,
    MODRM,
    REG_0,
    REG_1
} operand_e;

// Same order as the reg and rm encodings
typedef enum logic [2:0] {
    AW,
    CW,
    DW,
    BW,
    SP,
    BP,
    IX,
    IY
} reg16_e;

endpackage

/* source/v33_core_pkg.sv */
package v33_core_pkg;

typedef enum logic [1:0] {
    IDLE,
    FETCH_OPERAND,
    EXECUTE,
    STORE_RESULT
} seq_state_e;

// Arithmetic flags only
typedef struct packed {
    logic CY;
    logic P;
    logic Z;
    logic S;
    logic V;
} flags_t;

endpackage

/* source/register_file.sv */
`timescale 1ns/1ps
`include "v33_defs.svh"

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  v33_isa_pkg::reg16_e    rd_a_idx,
    input  v33_isa_pkg::reg16_e    rd_b_idx,
    input  logic                   wr_en,
    input  v33_isa_pkg::reg16_e    wr_idx,
    input  logic [`V33_WORD_W-1:0] wr_data,
    input  logic                   flags_wr,
    input  v33_core_pkg::flags_t   flags_in,
    input  logic                   cw_dec,
    output logic [`V33_WORD_W-1:0] rd_a_data,
    output logic [`V33_WORD_W-1:0] rd_b_data,
    output logic [`V33_WORD_W-1:0] cw,
    output v33_core_pkg::flags_t   flags,
    output logic [`V33_WORD_W-1:0] base_bw,
    output logic [`V33_WORD_W-1:0] base_bp,
    output logic [`V33_WORD_W-1:0] base_ix,
    output logic [`V33_WORD_W-1:0] base_iy
);

logic [`V33_WORD_W-1:0] regs [`V33_NUM_REGS];

always_ff @(posedge clk) begin
    if (reset) begin
        for (int i = 0; i < `V33_NUM_REGS; i++) begin
            regs[i] <= '0;
        end
        flags <= '0;
    end else begin
        for (int i = 0; i < `V33_NUM_REGS; i++) begin
            if (wr_en && int'(wr_idx) == i) begin
                regs[i] <= wr_data; // Write port wins over the decrement
            end else if (cw_dec && i == int'(v33_isa_pkg::CW)) begin
                regs[i] <= regs[i] - 1'b1;
            end
        end
        if (flags_wr) begin
            flags <= flags_in;
        end
    end
end

assign rd_a_data = regs[rd_a_idx];
assign rd_b_data = regs[rd_b_idx];
assign cw        = regs[v33_isa_pkg::CW];

// Address bases, separate from the read ports
assign base_bw = regs[v33_isa_pkg::BW];
assign base_bp = regs[v33_isa_pkg::BP];
assign base_ix = regs[v33_isa_pkg::IX];
assign base_iy = regs[v33_isa_pkg::IY];

endmodule

/* source/effective_address.sv */
`timescale 1ns/1ps
`include "v33_defs.svh"

module effective_address (
    input  logic [2:0]             rm,
    input  logic [1:0]             mod,
    input  logic [`V33_WORD_W-1:0] disp,
    input  logic [`V33_WORD_W-1:0] base_bw,
    input  logic [`V33_WORD_W-1:0] base_bp,
    input  logic [`V33_WORD_W-1:0] base_ix,
    input  logic [`V33_WORD_W-1:0] base_iy,
    output logic [`V33_WORD_W-1:0] ea
);

logic [`V33_WORD_W-1:0] base;

always_comb begin
    case (rm)
    3'd0: base = base_bw + base_ix;
    3'd1: base = base_bw + base_iy;
    3'd2: base = base_bp + base_ix;
    3'd3: base = base_bp + base_iy;
    3'd4: base = base_ix;
    3'd5: base = base_iy;
    3'd6: base = (mod == 2'd0) ? disp : base_bp; // Direct address
    default: base = base_bw;
    endcase

    case (mod)
    2'd1: ea = base + {8'd0, disp[7:0]};
    2'd2: ea = base + disp;
    default: ea = base;
    endcase
end

endmodule

/* source/alu.sv */
`timescale 1ns/1ps
`include "v33_defs.svh"

module alu (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  v33_isa_pkg::alu_op_e   op,
    input  logic [`V33_WORD_W-1:0] a,
    input  logic [`V33_WORD_W-1:0] b,
    output logic [`V33_WORD_W-1:0] result,
    output v33_core_pkg::flags_t   flags_out,
    output logic                   done
);

localparam int MSB = `V33_WORD_W - 1;

logic [`V33_WORD_W:0] wide; // Top bit is carry or borrow
logic [MSB:0] res;
logic ov;

always_comb begin
    ov = 1'b0;
    case (op)
    v33_isa_pkg::ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        ov = (a[MSB] == b[MSB]) && (wide[MSB] != a[MSB]);
    end
    v33_isa_pkg::SUB: begin
        wide = {1'b0, a} - {1'b0, b};
        ov = (a[MSB] != b[MSB]) && (wide[MSB] != a[MSB]);
    end
    v33_isa_pkg::AND: wide = {1'b0, a & b};
    v33_isa_pkg::OR:  wide = {1'b0, a | b};
    v33_isa_pkg::XOR: wide = {1'b0, a ^ b};
    default: wide = {1'b0, a};
    endcase
    res = wide[MSB:0];
end

always_ff @(posedge clk) begin
    if (reset) begin
        done <= 1'b0;
    end else begin
        done <= start;
    end
end

always_ff @(posedge clk) begin
    if (start) begin
        result       <= res;
        flags_out.CY <= wide[`V33_WORD_W]; // Cleared by logic ops
        flags_out.V  <= ov;
        flags_out.Z  <= (res == '0);
        flags_out.S  <= res[MSB];
        flags_out.P  <= ~^res[7:0]; // Even parity, low byte
    end
end

endmodule

/* source/exec_sequencer.sv */
`timescale 1ns/1ps
`include "v33_defs.svh"

module exec_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   op_valid,
    input  v33_isa_pkg::opcode_e   opcode,
    input  v33_isa_pkg::alu_op_e   alu_op,
    input  logic [`V33_COND_W-1:0] cond,
    input  v33_isa_pkg::operand_e  dest,
    input  v33_isa_pkg::operand_e  src0,
    input  v33_isa_pkg::operand_e  src1,
    input  v33_isa_pkg::reg16_e    reg0,
    input  v33_isa_pkg::reg16_e    reg1,
    input  logic [2:0]             rm,
    input  logic [1:0]             mod,
    input  logic [`V33_WORD_W-1:0] imm,
    input  logic [3:0]             op_len,
    output logic                   op_ready,
    output logic [`V33_WORD_W-1:0] pc,
    output logic                   mem_req,
    output logic                   mem_write,
    output logic [`V33_WORD_W-1:0] mem_addr,
    output logic [`V33_WORD_W-1:0] mem_wdata,
    input  logic                   mem_ack,
    input  logic [`V33_WORD_W-1:0] mem_rdata,
    output v33_isa_pkg::reg16_e    rd_a_idx,
    output v33_isa_pkg::reg16_e    rd_b_idx,
    input  logic [`V33_WORD_W-1:0] rd_a_data,
    input  logic [`V33_WORD_W-1:0] rd_b_data,
    output logic                   wr_en,
    output v33_isa_pkg::reg16_e    wr_idx,
    output logic [`V33_WORD_W-1:0] wr_data,
    output logic                   flags_wr,
    output logic                   cw_dec,
    input  logic [`V33_WORD_W-1:0] cw,
    input  v33_core_pkg::flags_t   flags,
    output logic                   alu_start,
    output v33_isa_pkg::alu_op_e   alu_func,
    output logic [`V33_WORD_W-1:0] alu_a,
    output logic [`V33_WORD_W-1:0] alu_b,
    input  logic [`V33_WORD_W-1:0] alu_result,
    input  logic                   alu_done,
    input  logic [`V33_WORD_W-1:0] ea
);

v33_core_pkg::seq_state_e state;
v33_isa_pkg::opcode_e     opcode_q;
v33_isa_pkg::operand_e    dest_q, src0_q, src1_q;
v33_isa_pkg::reg16_e      reg0_q, reg1_q;
logic [`V33_COND_W-1:0]   cond_q;
logic [2:0]               rm_q;
logic [1:0]               mod_q;
logic [`V33_WORD_W-1:0]   imm_q, mem_data_q, op_a, op_b;
logic store_wait; // Memory write outstanding
logic taken, dest_mem, dest_reg, issue_store;

// Memory operand read only for data-moving instructions
function automatic logic needs_read(input v33_isa_pkg::opcode_e opc,
                                    input v33_isa_pkg::operand_e s0,
                                    input v33_isa_pkg::operand_e s1,
                                    input logic [1:0] m);
    return (opc == v33_isa_pkg::MOV || opc == v33_isa_pkg::ALU) && m != 2'd3 &&
           (s0 == v33_isa_pkg::MODRM || s1 == v33_isa_pkg::MODRM);
endfunction

function automatic v33_isa_pkg::reg16_e reg_index(input v33_isa_pkg::operand_e sel);
    case (sel)
    v33_isa_pkg::REG_0: return reg0_q;
    v33_isa_pkg::REG_1: return reg1_q;
    v33_isa_pkg::MODRM: return v33_isa_pkg::reg16_e'(rm_q);
    default: return v33_isa_pkg::AW;
    endcase
endfunction

function automatic logic [`V33_WORD_W-1:0] operand_value(input v33_isa_pkg::operand_e sel,
                                                         input logic [`V33_WORD_W-1:0] rd);
    case (sel)
    v33_isa_pkg::NONE:  return '0;
    v33_isa_pkg::IMM:   return imm_q;
    v33_isa_pkg::MODRM: return (mod_q == 2'd3) ? rd : mem_data_q;
    default: return rd;
    endcase
endfunction

assign op_ready = (state == v33_core_pkg::IDLE);
assign rd_a_idx = reg_index(src0_q);
assign rd_b_idx = reg_index(src1_q);
assign wr_idx   = reg_index(dest_q);
assign op_a     = operand_value(src0_q, rd_a_data);
assign op_b     = operand_value(src1_q, rd_b_data);
assign alu_a    = op_a;
assign alu_b    = op_b;

assign dest_mem = (dest_q == v33_isa_pkg::MODRM) && mod_q != 2'd3;
assign dest_reg = (dest_q != v33_isa_pkg::NONE) && (dest_q != v33_isa_pkg::IMM) && !dest_mem;

assign alu_start = (state == v33_core_pkg::EXECUTE) && opcode_q == v33_isa_pkg::ALU;
assign flags_wr  = (state == v33_core_pkg::STORE_RESULT) && !store_wait && alu_done;
assign cw_dec    = (state == v33_core_pkg::FETCH_OPERAND) &&
                   opcode_q == v33_isa_pkg::B_CW_COND && cond_q < 4'd3;
assign issue_store = dest_mem && (flags_wr ||
                     ((state == v33_core_pkg::EXECUTE) && opcode_q == v33_isa_pkg::MOV));

always_comb begin
    wr_en   = 1'b0;
    wr_data = op_a;
    if (state == v33_core_pkg::EXECUTE && opcode_q == v33_isa_pkg::MOV) begin
        wr_en = dest_reg;
    end else if (flags_wr) begin
        wr_en   = dest_reg;
        wr_data = alu_result;
    end
end

// Branch decision, CW is the value before the decrement
always_comb begin
    taken = 1'b0;
    case (opcode_q)
    v33_isa_pkg::BR_REL: taken = 1'b1;
    v33_isa_pkg::B_COND: begin
        case (cond_q)
        4'd0:  taken = flags.V;
        4'd1:  taken = ~flags.V;
        4'd2:  taken = flags.CY;
        4'd3:  taken = ~flags.CY;
        4'd4:  taken = flags.Z;
        4'd5:  taken = ~flags.Z;
        4'd6:  taken = flags.CY | flags.Z;    // NH
        4'd7:  taken = ~(flags.CY | flags.Z); // H
        4'd8:  taken = flags.S;
        4'd9:  taken = ~flags.S;
        4'd10: taken = flags.P;
        4'd11: taken = ~flags.P;
        4'd12: taken = flags.S ^ flags.V;     // LT
        4'd13: taken = ~(flags.S ^ flags.V);
        4'd14: taken = (flags.S ^ flags.V) | flags.Z; // LE
        default: taken = ~((flags.S ^ flags.V) | flags.Z);
        endcase
    end
    v33_isa_pkg::B_CW_COND: begin
        case (cond_q)
        4'd0: taken = (cw != 16'd1) && !flags.Z;
        4'd1: taken = (cw != 16'd1) && flags.Z;
        4'd2: taken = (cw != 16'd1);
        4'd3: taken = (cw == '0);
        default: taken = 1'b0;
        endcase
    end
    default: taken = 1'b0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset) begin
        state      <= v33_core_pkg::IDLE;
        pc         <= '0;
        mem_req    <= 1'b0;
        mem_write  <= 1'b0;
        store_wait <= 1'b0;
    end else begin
        mem_req <= issue_store;
        if (issue_store) begin
            mem_write  <= 1'b1;
            store_wait <= 1'b1;
        end
        case (state)
        v33_core_pkg::IDLE: begin
            if (op_valid) begin
                pc        <= pc + {{(`V33_WORD_W - 4){1'b0}}, op_len};
                mem_req   <= needs_read(opcode, src0, src1, mod);
                mem_write <= 1'b0;
                state     <= v33_core_pkg::FETCH_OPERAND;
            end
        end
        v33_core_pkg::FETCH_OPERAND: begin
            if (opcode_q != v33_isa_pkg::MOV && opcode_q != v33_isa_pkg::ALU) begin
                if (taken) begin
                    pc <= pc + imm_q; // pc already advanced
                end
                state <= v33_core_pkg::IDLE;
            end else if (!needs_read(opcode_q, src0_q, src1_q, mod_q) || mem_ack) begin
                state <= v33_core_pkg::EXECUTE;
            end
        end
        v33_core_pkg::EXECUTE: begin
            if (opcode_q == v33_isa_pkg::ALU || dest_mem) begin
                state <= v33_core_pkg::STORE_RESULT;
            end else begin
                state <= v33_core_pkg::IDLE;
            end
        end
        default: begin
            if (store_wait && mem_ack) begin
                store_wait <= 1'b0;
                state      <= v33_core_pkg::IDLE;
            end else if (flags_wr && !dest_mem) begin
                state <= v33_core_pkg::IDLE;
            end
        end
        endcase
    end
end

always_ff @(posedge clk) begin
    if (op_ready && op_valid) begin
        opcode_q <= opcode;
        alu_func <= alu_op;
        cond_q   <= cond;
        dest_q   <= dest;
        src0_q   <= src0;
        src1_q   <= src1;
        reg0_q   <= reg0;
        reg1_q   <= reg1;
        rm_q     <= rm;
        mod_q    <= mod;
        imm_q    <= imm;
        mem_addr <= ea; // Used for both operand read and store
    end
    if (state == v33_core_pkg::FETCH_OPERAND && mem_ack) begin
        mem_data_q <= mem_rdata;
    end
    if (issue_store) begin
        mem_wdata <= (opcode_q == v33_isa_pkg::ALU) ? alu_result : op_a;
    end
end

endmodule

/* source/v33_core.sv */
`timescale 1ns/1ps
`include "v33_defs.svh"

module v33_core (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   op_valid,
    input  v33_isa_pkg::opcode_e   opcode,
    input  v33_isa_pkg::alu_op_e   alu_op,
    input  logic [`V33_COND_W-1:0] cond,
    input  v33_isa_pkg::operand_e  dest,
    input  v33_isa_pkg::operand_e  src0,
    input  v33_isa_pkg::operand_e  src1,
    input  v33_isa_pkg::reg16_e    reg0,
    input  v33_isa_pkg::reg16_e    reg1,
    input  logic [2:0]             rm,
    input  logic [1:0]             mod,
    input  logic [`V33_WORD_W-1:0] imm,
    input  logic [`V33_WORD_W-1:0] disp,
    input  logic [3:0]             op_len,
    output logic                   op_ready,
    output logic [`V33_WORD_W-1:0] pc,
    output logic [`V33_WORD_W-1:0] psw,
    output logic                   mem_req,
    output logic                   mem_write,
    output logic [`V33_WORD_W-1:0] mem_addr,
    output logic [`V33_WORD_W-1:0] mem_wdata,
    input  logic                   mem_ack,
    input  logic [`V33_WORD_W-1:0] mem_rdata
);

v33_isa_pkg::reg16_e    rd_a_idx, rd_b_idx, wr_idx;
v33_isa_pkg::alu_op_e   alu_func;
v33_core_pkg::flags_t   flags, alu_flags;
logic [`V33_WORD_W-1:0] rd_a_data, rd_b_data, wr_data, cw;
logic [`V33_WORD_W-1:0] base_bw, base_bp, base_ix, base_iy, ea;
logic [`V33_WORD_W-1:0] alu_a, alu_b, alu_result;
logic wr_en, flags_wr, cw_dec, alu_start, alu_done;

// Original PSW layout, unused flag positions read as zero
assign psw = {4'b1111, flags.V, 3'b000, flags.S, flags.Z, 3'b000, flags.P, 1'b1, flags.CY};

register_file u_regs (
    .clk, .reset,
    .rd_a_idx, .rd_b_idx, .wr_en, .wr_idx, .wr_data,
    .flags_wr, .flags_in(alu_flags), .cw_dec,
    .rd_a_data, .rd_b_data, .cw, .flags,
    .base_bw, .base_bp, .base_ix, .base_iy
);

effective_address u_ea (
    .rm, .mod, .disp,
    .base_bw, .base_bp, .base_ix, .base_iy,
    .ea
);

alu u_alu (
    .clk, .reset,
    .start(alu_start), .op(alu_func), .a(alu_a), .b(alu_b),
    .result(alu_result), .flags_out(alu_flags), .done(alu_done)
);

exec_sequencer u_seq (
    .clk, .reset,
    .op_valid, .opcode, .alu_op, .cond, .dest, .src0, .src1,
    .reg0, .reg1, .rm, .mod, .imm, .op_len,
    .op_ready, .pc,
    .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
    .rd_a_idx, .rd_b_idx, .rd_a_data, .rd_b_data,
    .wr_en, .wr_idx, .wr_data, .flags_wr, .cw_dec, .cw, .flags,
    .alu_start, .alu_func, .alu_a, .alu_b, .alu_result, .alu_done,
    .ea
);

endmodule

/* sim/v33_core_assertions.sv */
`timescale 1ns/1ps

module v33_core_assertions (
    input logic clk,
    input logic reset,
    input logic op_ready,
    input logic mem_req,
    input logic mem_ack
);

int error_count = 0;
logic outstanding; // Request sent, ack not yet seen

always_ff @(posedge clk) begin
    if (reset) begin
        outstanding <= 1'b0;
    end else if (mem_ack) begin
        outstanding <= 1'b0;
    end else if (mem_req) begin
        outstanding <= 1'b1;
    end
end

req_not_idle: assert property (@(posedge clk) disable iff (reset) op_ready |-> !mem_req)
    else begin
        $error("mem_req high while op_ready is high");
        error_count++;
    end

req_one_cycle: assert property (@(posedge clk) disable iff (reset) mem_req |=> !mem_req)
    else begin
        $error("mem_req held longer than one cycle");
        error_count++;
    end

req_after_ack: assert property (@(posedge clk) disable iff (reset) mem_req |-> !outstanding)
    else begin
        $error("new mem_req before mem_ack of the previous one");
        error_count++;
    end

endmodule

bind exec_sequencer v33_core_assertions seq_checks (
    .clk,
    .reset,
    .op_ready,
    .mem_req,
    .mem_ack
);

/* sim/v33_core_tb.sv */
`timescale 1ns/1ps
`include "v33_defs.svh"

module v33_core_tb;

localparam int TIMEOUT = 60; // Cycles allowed for any single wait

logic                          clk;
logic                          reset;
logic                          op_valid;
v33_isa_pkg::opcode_e          opcode;
v33_isa_pkg::alu_op_e          alu_op;
logic [`V33_COND_W-1:0]        cond;
v33_isa_pkg::operand_e         dest, src0, src1;
v33_isa_pkg::reg16_e           reg0, reg1;
logic [2:0]                    rm;
logic [1:0]                    mod;
logic [`V33_WORD_W-1:0]        imm, disp;
logic [3:0]                    op_len;
logic                          op_ready;
logic [`V33_WORD_W-1:0]        pc, psw;
logic                          mem_req, mem_write, mem_ack;
logic [`V33_WORD_W-1:0]        mem_addr, mem_wdata, mem_rdata;

// Shadow copy of the architectural state
logic [`V33_WORD_W-1:0] sh_regs [`V33_NUM_REGS];
v33_core_pkg::flags_t   sh_flags;
logic [`V33_WORD_W-1:0] sh_pc;

// Memory model state
logic [`V33_WORD_W-1:0] mem [256];
logic [`V33_WORD_W-1:0] req_addr, req_wdata, wr_addr_seen, wr_data_seen;
logic                   req_write, mem_busy, wr_seen;
logic [1:0]             mem_delay;
logic [15:0]            mem_lfsr = 16'd69;
logic [15:0]            stim_lfsr = 16'd69;

string                  name_q[$];
logic [`V33_WORD_W-1:0] exp_q[$], act_q[$];
int                     pass_count = 0;
int                     fail_count = 0;

v33_core UUT (
    .clk, .reset,
    .op_valid, .opcode, .alu_op, .cond, .dest, .src0, .src1,
    .reg0, .reg1, .rm, .mod, .imm, .disp, .op_len,
    .op_ready, .pc, .psw,
    .mem_req, .mem_write, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
);

always #50 clk = ~clk;

// Galois form, taps 16,14,13,11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[14:0], stim_lfsr[0]};
        stim_lfsr = lfsr_next(stim_lfsr);
    end
    return v;
endfunction

function automatic logic [15:0] fill_word(input logic [7:0] a);
    return {a ^ 8'hC3, ~a};
endfunction

// Flags record placed into the PSW layout
function automatic logic [15:0] psw_of(input v33_core_pkg::flags_t f);
    logic [15:0] p;
    p = 16'hF002;
    p[0]  = f.CY;
    p[2]  = f.P;
    p[6]  = f.Z;
    p[7]  = f.S;
    p[11] = f.V;
    return p;
endfunction

function automatic logic [15:0] ea_ref(input logic [2:0] r, input logic [1:0] m,
                                       input logic [15:0] d);
    logic [15:0] bw, bp, ix, iy, base;
    bw = sh_regs[v33_isa_pkg::BW];
    bp = sh_regs[v33_isa_pkg::BP];
    ix = sh_regs[v33_isa_pkg::IX];
    iy = sh_regs[v33_isa_pkg::IY];
    base = (r[2] == 1'b0) ? ((r[1] ? bp : bw) + (r[0] ? iy : ix)) :
           (r == 3'd4) ? ix : (r == 3'd5) ? iy : (r == 3'd7) ? bw :
           (m == 2'd0) ? d : bp;
    if (m == 2'd1) begin
        return base + {8'h00, d[7:0]};
    end else if (m == 2'd2) begin
        return base + d;
    end
    return base;
endfunction

// Result in the low 16 bits, flags above
function automatic logic [20:0] alu_ref(input v33_isa_pkg::alu_op_e op,
                                        input logic [15:0] a, input logic [15:0] b);
    logic [16:0] full;
    logic [15:0] r;
    v33_core_pkg::flags_t f;
    f = '0;
    case (op)
    v33_isa_pkg::ADD: begin
        full = {1'b0, a} + {1'b0, b};
        f.CY = full[16];
        f.V  = (a[15] == b[15]) && (full[15] != a[15]);
    end
    v33_isa_pkg::SUB: begin
        full = {1'b0, a - b};
        f.CY = (a < b); // Borrow
        f.V  = (a[15] != b[15]) && (full[15] != a[15]);
    end
    v33_isa_pkg::AND: full = {1'b0, a & b};
    v33_isa_pkg::OR:  full = {1'b0, a | b};
    v33_isa_pkg::XOR: full = {1'b0, a ^ b};
    default: full = {1'b0, a};
    endcase
    r = full[15:0];
    f.Z = (r == 16'd0);
    f.S = r[15];
    f.P = ~^r[7:0];
    return {f, r};
endfunction

function automatic logic branch_ref(input v33_isa_pkg::opcode_e opc, input logic [3:0] c,
                                    input v33_core_pkg::flags_t f, input logic [15:0] cw_old);
    logic base;
    if (opc == v33_isa_pkg::BR_REL) begin
        return 1'b1;
    end
    if (opc == v33_isa_pkg::B_CW_COND) begin
        if (c == 4'd3) begin
            return cw_old == 16'd0;
        end
        return (cw_old != 16'd1) && (c == 4'd2 || f.Z == c[0]);
    end
    case (c[3:1]) // Odd codes invert the even one
    3'd0: base = f.V;
    3'd1: base = f.CY;
    3'd2: base = f.Z;
    3'd3: base = f.CY | f.Z;
    3'd4: base = f.S;
    3'd5: base = f.P;
    3'd6: base = f.S ^ f.V;
    default: base = (f.S ^ f.V) | f.Z;
    endcase
    return base ^ c[0];
endfunction

task automatic finish_run();
    int fails;
    fails = fail_count + UUT.u_seq.seq_checks.error_count;
    $display("Checks passed %0d, failed %0d, assertion failures %0d",
             pass_count, fail_count, UUT.u_seq.seq_checks.error_count);
    if (fails == 0) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
endtask

task automatic expect_val(input string name, input logic [15:0] e, input logic [15:0] a);
    name_q.push_back(name);
    exp_q.push_back(e);
    act_q.push_back(a);
endtask

task automatic wait_ready();
    int i;
    for (i = 0; i < TIMEOUT; i++) begin
        @(negedge clk);
        if (op_ready) break;
    end
    if (i == TIMEOUT) begin
        $display("Timeout: op_ready stayed low for %0d cycles", TIMEOUT);
        fail_count++;
        finish_run();
    end
endtask

task automatic issue(input v33_isa_pkg::opcode_e opc, input v33_isa_pkg::alu_op_e aop,
                     input logic [3:0] cnd, input v33_isa_pkg::operand_e dst,
                     input v33_isa_pkg::operand_e s0, input v33_isa_pkg::operand_e s1,
                     input v33_isa_pkg::reg16_e r0, input v33_isa_pkg::reg16_e r1,
                     input logic [2:0] rmv, input logic [1:0] modv,
                     input logic [15:0] immv, input logic [15:0] dispv, input logic [3:0] len);
    wait_ready();
    wr_seen = 1'b0;
    @(posedge clk);
    op_valid <= 1'b1;
    opcode   <= opc;
    alu_op   <= aop;
    cond     <= cnd;
    dest     <= dst;
    src0     <= s0;
    src1     <= s1;
    reg0     <= r0;
    reg1     <= r1;
    rm       <= rmv;
    mod      <= modv;
    imm      <= immv;
    disp     <= dispv;
    op_len   <= len;
    @(posedge clk);
    op_valid <= 1'b0;
    sh_pc = sh_pc + len;
    wait_ready();
endtask

task automatic load_reg(input v33_isa_pkg::reg16_e r, input logic [15:0] value);
    issue(v33_isa_pkg::MOV, v33_isa_pkg::PASS, 4'd0, v33_isa_pkg::REG_0, v33_isa_pkg::IMM,
          v33_isa_pkg::NONE, r, v33_isa_pkg::AW, 3'd0, 2'd3, value, 16'd0, 4'd3);
    sh_regs[r] = value;
endtask

task automatic check_write(input string name, input logic [15:0] addr, input logic [15:0] data);
    expect_val({name, " write"}, 16'd1, {15'd0, wr_seen});
    expect_val({name, " addr"}, addr, wr_addr_seen);
    expect_val({name, " data"}, data, wr_data_seen);
endtask

task automatic store_reg(input string name, input v33_isa_pkg::reg16_e r,
                         input logic [2:0] rmv, input logic [1:0] modv, input logic [15:0] dispv);
    logic [15:0] addr;
    addr = ea_ref(rmv, modv, dispv);
    issue(v33_isa_pkg::MOV, v33_isa_pkg::PASS, 4'd0, v33_isa_pkg::MODRM, v33_isa_pkg::REG_0,
          v33_isa_pkg::NONE, r, v33_isa_pkg::AW, rmv, modv, 16'd0, dispv, 4'd3);
    check_write(name, addr, sh_regs[r]);
endtask

// Memory answers each request after 0 to 3 cycles
always @(posedge clk) begin
    mem_ack <= 1'b0;
    if (reset) begin
        mem_busy = 1'b0;
    end else begin
        if (mem_req) begin
            req_write = mem_write;
            req_addr  = mem_addr;
            req_wdata = mem_wdata;
            mem_delay[0] = mem_lfsr[0];
            mem_lfsr = lfsr_next(mem_lfsr);
            mem_delay[1] = mem_lfsr[0];
            mem_lfsr = lfsr_next(mem_lfsr);
            mem_busy = 1'b1;
        end else if (mem_busy && mem_delay != 2'd0) begin
            mem_delay = mem_delay - 1'b1;
        end
        if (mem_busy && mem_delay == 2'd0) begin
            mem_busy = 1'b0;
            mem_ack <= 1'b1;
            if (req_write) begin
                mem[req_addr[7:0]] = req_wdata;
                wr_seen      = 1'b1;
                wr_addr_seen = req_addr;
                wr_data_seen = req_wdata;
            end else begin
                mem_rdata <= mem[req_addr[7:0]];
            end
        end
    end
end

// Compare process
always @(negedge clk) begin
    string nm;
    logic [15:0] e_val, a_val;
    while (name_q.size() > 0) begin
        nm    = name_q.pop_front();
        e_val = exp_q.pop_front();
        a_val = act_q.pop_front();
        assert (a_val === e_val) begin
            pass_count++;
            $display("ok       %s = %h", nm, a_val);
        end else begin
            fail_count++;
            $display("MISMATCH %s expected %h actual %h", nm, e_val, a_val);
        end
    end
end

initial begin
    logic [20:0] exp_r;
    logic [15:0] a, b, k, cw_pre, exp_mem;
    logic [3:0] len;
    v33_isa_pkg::alu_op_e op;
    int i;

    clk = 1'b0;
    reset = 1'b1;
    op_valid = 1'b0;
    opcode = v33_isa_pkg::NOP;
    alu_op = v33_isa_pkg::PASS;
    cond = '0;
    dest = v33_isa_pkg::NONE;
    src0 = v33_isa_pkg::NONE;
    src1 = v33_isa_pkg::NONE;
    reg0 = v33_isa_pkg::AW;
    reg1 = v33_isa_pkg::AW;
    rm = '0;
    mod = '0;
    imm = '0;
    disp = '0;
    op_len = '0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    wr_seen = 1'b0;
    wr_addr_seen = '0;
    wr_data_seen = '0;
    for (int j = 0; j < 256; j++) begin
        mem[j] = fill_word(j[7:0]);
    end
    for (int j = 0; j < `V33_NUM_REGS; j++) begin
        sh_regs[j] = '0;
    end
    sh_flags = '0;
    sh_pc = '0;

    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    expect_val("reset op_ready", 16'd1, {15'd0, op_ready});
    expect_val("reset pc", 16'd0, pc);
    expect_val("reset psw", psw_of(sh_flags), psw);

    // Immediate into registers, then out to memory
    load_reg(v33_isa_pkg::BW, 16'h0040);
    load_reg(v33_isa_pkg::IX, 16'h0010);
    load_reg(v33_isa_pkg::AW, 16'h1234);
    store_reg("mov bw+ix+d8", v33_isa_pkg::AW, 3'd0, 2'd1, 16'h0005);
    store_reg("mov direct", v33_isa_pkg::AW, 3'd6, 2'd0, 16'h0080);

    for (i = 0; i < 10; i++) begin
        a = rand_bits(16);
        b = rand_bits(16);
        op = v33_isa_pkg::alu_op_e'(rand_bits(3) % 5);
        load_reg(v33_isa_pkg::AW, a);
        load_reg(v33_isa_pkg::DW, b);
        exp_r = alu_ref(op, a, b);
        issue(v33_isa_pkg::ALU, op, 4'd0, v33_isa_pkg::MODRM, v33_isa_pkg::ACC,
              v33_isa_pkg::REG_1, v33_isa_pkg::AW, v33_isa_pkg::DW, 3'd6, 2'd0,
              16'd0, 16'h0090 + i[15:0], 4'd2);
        sh_flags = exp_r[20:16];
        check_write($sformatf("alu %s %0d", op.name(), i), 16'h0090 + i[15:0], exp_r[15:0]);
        expect_val($sformatf("alu %s %0d psw", op.name(), i), psw_of(sh_flags), psw);
    end

    // Read-modify-write at BP+IY+disp16
    load_reg(v33_isa_pkg::BP, 16'h0020);
    load_reg(v33_isa_pkg::IY, 16'h0008);
    exp_mem = fill_word(ea_ref(3'd3, 2'd2, 16'h0030));
    for (i = 0; i < 6; i++) begin
        k = rand_bits(16);
        op = v33_isa_pkg::alu_op_e'(rand_bits(3) % 5);
        exp_r = alu_ref(op, exp_mem, k);
        issue(v33_isa_pkg::ALU, op, 4'd0, v33_isa_pkg::MODRM, v33_isa_pkg::MODRM,
              v33_isa_pkg::IMM, v33_isa_pkg::AW, v33_isa_pkg::AW, 3'd3, 2'd2, k, 16'h0030, 4'd3);
        sh_flags = exp_r[20:16];
        check_write($sformatf("rmw %s %0d", op.name(), i), ea_ref(3'd3, 2'd2, 16'h0030),
                    exp_r[15:0]);
        expect_val($sformatf("rmw %s %0d psw", op.name(), i), psw_of(sh_flags), psw);
        exp_mem = exp_r[15:0];
    end

    for (i = 0; i < 16; i++) begin
        k = rand_bits(16);
        op = v33_isa_pkg::alu_op_e'(rand_bits(3) % 5);
        exp_r = alu_ref(op, sh_regs[v33_isa_pkg::AW], k);
        issue(v33_isa_pkg::ALU, op, 4'd0, v33_isa_pkg::ACC, v33_isa_pkg::ACC,
              v33_isa_pkg::IMM, v33_isa_pkg::AW, v33_isa_pkg::AW, 3'd0, 2'd3, k, 16'd0, 4'd3);
        sh_regs[v33_isa_pkg::AW] = exp_r[15:0];
        sh_flags = exp_r[20:16];
        k = rand_bits(16);
        len = rand_bits(2) + 4'd1;
        issue(v33_isa_pkg::B_COND, v33_isa_pkg::PASS, i[3:0], v33_isa_pkg::NONE,
              v33_isa_pkg::NONE, v33_isa_pkg::NONE, v33_isa_pkg::AW, v33_isa_pkg::AW,
              3'd0, 2'd3, k, 16'd0, len);
        if (branch_ref(v33_isa_pkg::B_COND, i[3:0], sh_flags, 16'd0)) begin
            sh_pc = sh_pc + k;
        end
        expect_val($sformatf("bcond %0d pc", i), sh_pc, pc);
    end

    k = rand_bits(16);
    issue(v33_isa_pkg::BR_REL, v33_isa_pkg::PASS, 4'd0, v33_isa_pkg::NONE, v33_isa_pkg::NONE,
          v33_isa_pkg::NONE, v33_isa_pkg::AW, v33_isa_pkg::AW, 3'd0, 2'd3, k, 16'd0, 4'd2);
    sh_pc = sh_pc + k;
    expect_val("br_rel pc", sh_pc, pc);

    // CW loop branches over presets 0, 1 and 3
    for (i = 0; i < 24; i++) begin
        cw_pre = (i / 8 == 2) ? 16'd3 : 16'(i / 8);
        load_reg(v33_isa_pkg::CW, cw_pre);
        k = (i % 2 == 1) ? 16'h0000 : 16'h0001; // Odd steps set Z
        exp_r = alu_ref(v33_isa_pkg::AND, k, k);
        issue(v33_isa_pkg::ALU, v33_isa_pkg::AND, 4'd0, v33_isa_pkg::NONE, v33_isa_pkg::IMM,
              v33_isa_pkg::IMM, v33_isa_pkg::AW, v33_isa_pkg::AW, 3'd0, 2'd3, k, 16'd0, 4'd3);
        sh_flags = exp_r[20:16];
        k = rand_bits(16);
        issue(v33_isa_pkg::B_CW_COND, v33_isa_pkg::PASS, 4'((i / 2) % 4), v33_isa_pkg::NONE,
              v33_isa_pkg::NONE, v33_isa_pkg::NONE, v33_isa_pkg::AW, v33_isa_pkg::AW,
              3'd0, 2'd3, k, 16'd0, 4'd2);
        if (branch_ref(v33_isa_pkg::B_CW_COND, 4'((i / 2) % 4), sh_flags, cw_pre)) begin
            sh_pc = sh_pc + k;
        end
        if ((i / 2) % 4 != 3) begin
            sh_regs[v33_isa_pkg::CW] = cw_pre - 16'd1;
        end
        expect_val($sformatf("bcw %0d pc", i), sh_pc, pc);
        store_reg($sformatf("bcw %0d cw", i), v33_isa_pkg::CW, 3'd6, 2'd0, 16'h00A0);
    end

    for (i = 0; i < TIMEOUT; i++) begin
        @(negedge clk);
        if (name_q.size() == 0) break;
    end
    if (i == TIMEOUT) begin
        $display("Timeout: compare queue did not drain");
        fail_count++;
    end
    finish_run();
end

endmodule

/* all.f */
+incdir+source
source/v33_isa_pkg.sv
source/v33_core_pkg.sv
source/register_file.sv
source/effective_address.sv
source/alu.sv
source/exec_sequencer.sv
source/v33_core.sv
sim/v33_core_assertions.sv
sim/v33_core_tb.sv

/* Bender.yml */
package:
  name: v33_core

sources:
  - include_dirs:
      - source
    files:
      - source/v33_isa_pkg.sv
      - source/v33_core_pkg.sv
      - source/register_file.sv
      - source/effective_address.sv
      - source/alu.sv
      - source/exec_sequencer.sv
      - source/v33_core.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/v33_core_assertions.sv
      - sim/v33_core_tb.sv
